// File: dv/iob_trace.txt
# op and fields: K scan | M head middle tail x y rawx rawy | D cycles
# W addr data | R addr expected mode (e exact, m at least previous plus value, o outside)
D 4
W 17772045 00000005
R 17772045 00000005 e
R 17760045 00000000 o
W 17772045 00000002
K 12345678
R 17772045 00000022 e
R 17772040 00005678 e
R 17772041 00001234 e
R 17772045 00000002 e
W 17772045 00000001
M 1 0 1 abc 123 2 1
R 17772045 00000011 e
R 17772043 00006abc e
R 17772045 00000011 e
R 17772042 00005123 e
R 17772045 00000001 e
R 17772050 00000000 m
D 100
R 17772050 00000012 m
R 17772051 00000000 e
W 17772045 00000006
K 0000beef
R 17772052 00000000 e
D 100
R 17772045 00000066 e
R 17772052 00000002 m
R 17772040 0000beef e
R 17772044 00000000 e
R 17772047 00000000 e
D 10

// File: xbus_iob.f
hw/iob_pkg.sv
hw/iob_decode.sv
hw/iob_timers.sv
hw/iob_regs.sv
hw/iob_result.sv
hw/xbus_iob.sv
dv/iob_checker.sv
dv/xbus_iob_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := xbus_iob_tb
FILELIST := xbus_iob.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/xbus_iob_tb.sv
// i/o board testbench
module xbus_iob_tb;

   localparam int us_div = 5;
   localparam int hz60_div = 40;
   localparam int ack_limit = 16;
   localparam logic [1:0] mode_exact = 2'd0;
   localparam logic [1:0] mode_mono = 2'd1;
   localparam logic [1:0] mode_outside = 2'd2;

   // one parsed line of the trace
   typedef struct packed {
      logic [7:0]          op;
      logic [21:0]         addr;
      logic [31:0]         data;
      logic [1:0]          mode;
      iob_pkg::mouse_evt_t mouse;
   } entry_t;

   logic                clk;
   logic                reset;
   logic                req;
   logic [21:0]         addr;
   logic [31:0]         datain;
   logic                write;
   logic                key_strobe;
   logic [31:0]         key_scan;
   logic                mouse_strobe;
   iob_pkg::mouse_evt_t mouse;
   logic [31:0]         dataout;
   logic                ack;
   logic                decode;
   logic                interrupt;
   logic [7:0]          vector;

   entry_t trace[$];
   int     cycle_sum;
   int     bus_errors;
   bit     loaded;

   xbus_iob #(
      .us_div   (us_div),
      .hz60_div (hz60_div)
   ) xbus_iob_i (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .addr         (addr),
      .datain       (datain),
      .write        (write),
      .key_strobe   (key_strobe),
      .key_scan     (key_scan),
      .mouse_strobe (mouse_strobe),
      .mouse        (mouse),
      .dataout      (dataout),
      .ack          (ack),
      .decode       (decode),
      .interrupt    (interrupt),
      .vector       (vector)
   );

   iob_checker #(
      .hz60_div (hz60_div)
   ) checker_i (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .addr         (addr),
      .datain       (datain),
      .write        (write),
      .key_strobe   (key_strobe),
      .mouse_strobe (mouse_strobe),
      .dataout      (dataout),
      .ack          (ack),
      .decode       (decode),
      .interrupt    (interrupt),
      .vector       (vector)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic load_trace();
      int          fd;
      int          code;
      int          cnt;
      string       tok;
      string       mode_s;
      string       rest;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] mf [0:6];
      entry_t      e;
      fd = $fopen("dv/iob_trace.txt", "r");
      if (fd == 0)
      begin
         bus_errors++;
         $display("cannot open the trace file dv/iob_trace.txt");
         return;
      end
      code = $fscanf(fd, " %s", tok);
      while (code == 1)
      begin
         e = '0;
         if (tok.substr(0, 0) == "#")
            code = $fgets(rest, fd);
         else if (tok == "K")
         begin
            code = $fscanf(fd, " %h", d);
            e.op = "K";
            e.data = d;
            trace.push_back(e);
         end
         else if (tok == "M")
         begin
            code = $fscanf(fd, " %h %h %h %h %h %h %h",
                           mf[0], mf[1], mf[2], mf[3], mf[4], mf[5], mf[6]);
            e.op = "M";
            e.mouse = '{head: mf[0][0], middle: mf[1][0], tail: mf[2][0],
                        x: mf[3][11:0], y: mf[4][11:0], rawx: mf[5][1:0], rawy: mf[6][1:0]};
            trace.push_back(e);
         end
         else if (tok == "W" || tok == "R")
         begin
            if (tok == "W")
               code = $fscanf(fd, " %o %h", a, d);
            else
               code = $fscanf(fd, " %o %h %s", a, d, mode_s);
            e.op = (tok == "W") ? "W" : "R";
            e.addr = a[21:0];
            e.data = d;
            if (tok == "R" && mode_s == "m")
               e.mode = mode_mono;
            else if (tok == "R" && mode_s == "o")
               e.mode = mode_outside;
            else
               e.mode = mode_exact;
            trace.push_back(e);
         end
         else if (tok == "D")
         begin
            code = $fscanf(fd, " %d", cnt);
            e.op = "D";
            e.data = cnt;
            cycle_sum += cnt;
            trace.push_back(e);
         end
         else
         begin
            bus_errors++;
            $display("unknown operation %s in the trace file", tok);
            break;
         end
         code = $fscanf(fd, " %s", tok);
      end
      $fclose(fd);
   endtask

   task automatic key_event(input logic [31:0] scan);
      @(posedge clk);
      key_strobe <= 1'b1;
      key_scan <= scan;
      @(posedge clk);
      key_strobe <= 1'b0;
   endtask

   task automatic mouse_event(input iob_pkg::mouse_evt_t m);
      @(posedge clk);
      mouse_strobe <= 1'b1;
      mouse <= m;
      @(posedge clk);
      mouse_strobe <= 1'b0;
   endtask

   // hold the request until ack, then wait for ack to fall
   task automatic bus_access(input logic [21:0] a, input logic [31:0] d,
                             input logic w, input logic outside);
      int n;
      n = 0;
      @(posedge clk);
      req <= 1'b1;
      addr <= a;
      datain <= d;
      write <= w;
      if (outside)
      begin
         // nothing answers outside the window
         repeat (4) @(posedge clk);
         req <= 1'b0;
      end
      else
      begin
         do
         begin
            @(negedge clk);
            n++;
         end while (!ack && n < ack_limit);
         if (!ack)
         begin
            bus_errors++;
            $display("no ack from address %o within %0d cycles", a, ack_limit);
         end
         @(posedge clk);
         req <= 1'b0;
         n = 0;
         while (ack && n < ack_limit)
         begin
            @(negedge clk);
            n++;
         end
         if (ack)
         begin
            bus_errors++;
            $display("ack stayed high after the request to %o was dropped", a);
         end
      end
   endtask

   task automatic run_entry(input entry_t e);
      case (e.op)
         "K": key_event(e.data);
         "M": mouse_event(e.mouse);
         "W": bus_access(e.addr, e.data, 1'b1, 1'b0);
         "R":
         begin
            if (e.mode != mode_outside)
               checker_i.expect_read(e.addr[5:0], e.data, e.mode == mode_mono);
            bus_access(e.addr, 32'd0, 1'b0, e.mode == mode_outside);
         end
         "D": repeat (e.data) @(posedge clk);
         default: ;
      endcase
   endtask

   task automatic finish_run();
      int pend;
      pend = checker_i.pending_reads();
      if (pend != 0)
      begin
         bus_errors++;
         $display("%0d expected reads were never acked", pend);
      end
      $display("errors: %0d check, %0d bus", checker_i.check_errors, bus_errors);
      if (checker_i.check_errors == 0 && bus_errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   initial
   begin
      reset = 1'b1;
      req = 1'b0;
      addr = '0;
      datain = '0;
      write = 1'b0;
      key_strobe = 1'b0;
      key_scan = '0;
      mouse_strobe = 1'b0;
      mouse = '0;
      cycle_sum = 0;
      bus_errors = 0;
      loaded = 1'b0;
      load_trace();
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      foreach (trace[i])
         run_entry(trace[i]);
      repeat (4) @(posedge clk);
      finish_run();
   end

   // watchdog
   initial
   begin
      wait (loaded);
      repeat (20 * cycle_sum + 1000) @(posedge clk);
      $display("watchdog expired after %0d cycles", 20 * cycle_sum + 1000);
      $display("errors: %0d check, %0d bus", checker_i.check_errors, bus_errors);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: dv/iob_checker.sv
// i/o board bus and interrupt checker
module iob_checker #(
   parameter int hz60_div = 40
) (
   input logic        clk,
   input logic        reset,
   input logic        req,
   input logic [21:0] addr,
   input logic [31:0] datain,
   input logic        write,
   input logic        key_strobe,
   input logic        mouse_strobe,
   input logic [31:0] dataout,
   input logic        ack,
   input logic        decode,
   input logic        interrupt,
   input logic [7:0]  vector
);

   logic [5:0]  exp_off_q[$];
   logic [31:0] exp_val_q[$];
   logic        exp_mono_q[$];
   logic [31:0] last_val [0:63];
   int          check_errors;

   // bus timing history
   logic dec_d1;
   logic dec_d2;
   logic ack_d;

   // reference interrupt state
   logic [3:0] csr_m;
   logic [2:0] rdy_m;
   logic       en_m;
   logic       tick_m;
   logic       tick_n;
   int         pre_m;
   logic       in_win;
   logic       rd;
   logic [2:0] clr;
   logic [2:0] pend;
   logic [7:0] vec_m;
   logic [5:0] off;
   logic [31:0] exp_v;
   logic        mono;

   task automatic expect_read(input logic [5:0] o, input logic [31:0] v, input logic m);
      exp_off_q.push_back(o);
      exp_val_q.push_back(v);
      exp_mono_q.push_back(m);
   endtask

   function automatic int pending_reads();
      return exp_off_q.size();
   endfunction

   task automatic report(input string msg);
      check_errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   initial
   begin
      check_errors = 0;
      for (int i = 0; i < 64; i++)
         last_val[i] = '0;
   end

   always @(negedge clk)
   begin
      if (reset)
      begin
         dec_d1 = 1'b0;
         dec_d2 = 1'b0;
         ack_d = 1'b0;
         csr_m = '0;
         rdy_m = '0;
         en_m = 1'b0;
         tick_m = 1'b0;
         pre_m = 0;
      end
      else
      begin
         in_win = addr[21:6] == iob_pkg::iob_base[21:6];
         if (decode !== (req && in_win))
            report($sformatf("decode %b for address %o with req %b", decode, addr, req));
         if (ack !== dec_d2)
            report($sformatf("ack %b, expected %b two cycles after decode", ack, dec_d2));

         pend = rdy_m & csr_m[2:0];
         if (pend[2])
            vec_m = iob_pkg::vec_clk;
         else if (pend[1])
            vec_m = iob_pkg::vec_kbd;
         else if (pend[0])
            vec_m = iob_pkg::vec_mouse;
         else
            vec_m = 8'd0;
         if (interrupt !== (|pend) || vector !== vec_m)
            report($sformatf("interrupt %b vector %o, expected %b and %o",
                             interrupt, vector, |pend, vec_m));

         // first ack cycle of a read
         if (ack && !ack_d && !write)
         begin
            if (exp_off_q.size() == 0)
               report($sformatf("read of %o acked with no expected value", addr));
            else
            begin
               off = exp_off_q.pop_front();
               exp_v = exp_val_q.pop_front();
               mono = exp_mono_q.pop_front();
               if (!mono && dataout !== exp_v)
                  report($sformatf("offset %o read %h, expected %h", off, dataout, exp_v));
               if (mono && dataout < last_val[off] + exp_v)
                  report($sformatf("offset %o read %h, expected at least %h",
                                   off, dataout, last_val[off] + exp_v));
               last_val[off] = dataout;
            end
         end

         // advance the reference to the next rising edge
         rd = req && in_win && !write;
         clr[0] = rd && addr[5:0] == iob_pkg::mouse_y;
         clr[1] = rd && (addr[5:0] == iob_pkg::kbd_lo || addr[5:0] == iob_pkg::kbd_hi);
         clr[2] = rd && addr[5:0] == iob_pkg::hz60;
         tick_n = en_m && pre_m == hz60_div - 1;
         if (en_m)
            pre_m = (pre_m == hz60_div - 1) ? 0 : pre_m + 1;
         rdy_m = (rdy_m | {tick_m, key_strobe, mouse_strobe}) & ~clr;
         en_m = en_m | clr[2];
         tick_m = tick_n;
         if (req && in_win && write && addr[5:0] == iob_pkg::kbd_csr)
            csr_m = datain[3:0];

         dec_d2 = dec_d1;
         dec_d1 = req && in_win;
         ack_d = ack;
      end
   end

endmodule

// File: hw/xbus_iob.sv
// i/o board top level
module xbus_iob #(
   parameter int unsigned us_div   = iob_pkg::us_div_default,
   parameter int unsigned hz60_div = iob_pkg::hz60_div_default
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                req,
   input  logic [21:0]         addr,
   input  logic [31:0]         datain,
   input  logic                write,
   input  logic                key_strobe,
   input  logic [31:0]         key_scan,
   input  logic                mouse_strobe,
   input  iob_pkg::mouse_evt_t mouse,
   output logic [31:0]         dataout,
   output logic                ack,
   output logic                decode,
   output logic                interrupt,
   output logic [7:0]          vector
);

   iob_pkg::bus_req_t breq;
   iob_pkg::iob_op_t  op;
   iob_pkg::timer_t   timers;
   logic [31:0]       rdata;
   logic              hz60_enable;

   assign breq = '{addr: addr, wdata: datain, write: write};

   iob_decode decode_i (
      .req    (req),
      .breq   (breq),
      .decode (decode),
      .op     (op)
   );

   iob_regs regs_i (
      .clk          (clk),
      .reset        (reset),
      .op           (op),
      .timers       (timers),
      .key_strobe   (key_strobe),
      .key_scan     (key_scan),
      .mouse_strobe (mouse_strobe),
      .mouse        (mouse),
      .rdata        (rdata),
      .hz60_enable  (hz60_enable),
      .interrupt    (interrupt),
      .vector       (vector)
   );

   iob_timers #(
      .us_div   (us_div),
      .hz60_div (hz60_div)
   ) timers_i (
      .clk         (clk),
      .reset       (reset),
      .hz60_enable (hz60_enable),
      .timers      (timers)
   );

   iob_result result_i (
      .clk     (clk),
      .reset   (reset),
      .decode  (decode),
      .rdata   (rdata),
      .dataout (dataout),
      .ack     (ack)
   );

endmodule

// File: hw/iob_result.sv
// i/o board result stage
module iob_result (
   input  logic        clk,
   input  logic        reset,
   input  logic        decode,
   input  logic [31:0] rdata,
   output logic [31:0] dataout,
   output logic        ack
);

   logic [1:0] ack_q;

   // ack follows decode by two cycles
   always_ff @(posedge clk)
   begin
      if (reset)
         ack_q <= '0;
      else
         ack_q <= {ack_q[0], decode};
   end

   // sample on the first decode cycle, hold for the rest of the access
   always_ff @(posedge clk)
   begin
      if (!decode)
         dataout <= '0;
      else if (!ack_q[0])
         dataout <= rdata;
   end

   assign ack = ack_q[1];

endmodule

// File: hw/iob_regs.sv
// i/o board execute stage
module iob_regs (
   input  logic                clk,
   input  logic                reset,
   input  iob_pkg::iob_op_t    op,
   input  iob_pkg::timer_t     timers,
   input  logic                key_strobe,
   input  logic [31:0]         key_scan,
   input  logic                mouse_strobe,
   input  iob_pkg::mouse_evt_t mouse,
   output logic [31:0]         rdata,
   output logic                hz60_enable,
   output logic                interrupt,
   output logic [7:0]          vector
);

   logic [3:0]          csr;
   logic [2:0]          rdy;
   logic [2:0]          rdy_set;
   logic [2:0]          rdy_clr;
   logic [2:0]          pending;
   logic                rd;
   logic [31:0]         key_q;
   iob_pkg::mouse_evt_t mouse_q;

   assign rd = op.valid & ~op.write;

   // ready bits: 0 mouse, 1 keyboard, 2 clock
   assign rdy_set = {timers.hz60_tick, key_strobe, mouse_strobe};
   assign rdy_clr[0] = rd & op.sel[iob_pkg::sel_mouse_y];
   assign rdy_clr[1] = rd & (op.sel[iob_pkg::sel_kbd_lo] | op.sel[iob_pkg::sel_kbd_hi]);
   assign rdy_clr[2] = rd & op.sel[iob_pkg::sel_hz60];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csr <= '0;
         rdy <= '0;
         hz60_enable <= 1'b0;
      end
      else
      begin
         // a read in the same cycle wins over a new event
         rdy <= (rdy | rdy_set) & ~rdy_clr;
         if (op.valid && op.write && op.sel[iob_pkg::sel_kbd_csr])
            csr <= op.wdata[3:0];
         // first hz60 read starts the clock
         if (rdy_clr[2])
            hz60_enable <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (key_strobe)
         key_q <= key_scan;
      if (mouse_strobe)
         mouse_q <= mouse;
   end

   // beep and unused offsets fall through to zero
   always_comb
   begin
      rdata = '0;
      case (1'b1)
         op.sel[iob_pkg::sel_kbd_lo]:  rdata = {16'b0, key_q[15:0]};
         op.sel[iob_pkg::sel_kbd_hi]:  rdata = {16'b0, key_q[31:16]};
         op.sel[iob_pkg::sel_mouse_y]:
            rdata = {17'b0, mouse_q.head, mouse_q.middle, mouse_q.tail, mouse_q.y};
         op.sel[iob_pkg::sel_mouse_x]:
            rdata = {16'b0, mouse_q.rawy, mouse_q.rawx, mouse_q.x};
         op.sel[iob_pkg::sel_kbd_csr]: rdata = {25'b0, rdy, csr};
         op.sel[iob_pkg::sel_usec_lo]: rdata = {16'b0, timers.us_count[15:0]};
         op.sel[iob_pkg::sel_usec_hi]: rdata = {16'b0, timers.us_count[31:16]};
         op.sel[iob_pkg::sel_hz60]:    rdata = timers.hz60_count;
         default:                      rdata = '0;
      endcase
   end

   assign pending = rdy & csr[2:0];
   assign interrupt = |pending;

   // clock first, then keyboard, then mouse
   always_comb
   begin
      if (pending[2])
         vector = iob_pkg::vec_clk;
      else if (pending[1])
         vector = iob_pkg::vec_kbd;
      else if (pending[0])
         vector = iob_pkg::vec_mouse;
      else
         vector = 8'd0;
   end

   a_vector_idle: assert property (@(posedge clk) disable iff (reset)
      !interrupt |-> vector == 8'd0);

endmodule

// File: hw/iob_timers.sv
// microsecond and 60 Hz timers
module iob_timers #(
   parameter int unsigned us_div   = iob_pkg::us_div_default,
   parameter int unsigned hz60_div = iob_pkg::hz60_div_default
) (
   input  logic            clk,
   input  logic            reset,
   input  logic            hz60_enable,
   output iob_pkg::timer_t timers
);

   localparam int us_w = (us_div > 1) ? $clog2(us_div) : 1;
   localparam int hz_w = iob_pkg::hz60_div_w;
   localparam logic [us_w-1:0] us_last = us_w'(us_div - 1);
   localparam logic [hz_w-1:0] hz_last = hz_w'(hz60_div - 1);

   logic [us_w-1:0] us_pre;
   logic [hz_w-1:0] hz_pre;
   logic [31:0]     us_count;
   logic [31:0]     hz_count;
   logic            hz_tick;

   // free running from reset
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         us_pre <= '0;
         us_count <= '0;
      end
      else if (us_pre == us_last)
      begin
         us_pre <= '0;
         us_count <= us_count + 32'd1;
      end
      else
         us_pre <= us_pre + us_w'(1);
   end

   // 60 Hz prescaler only runs once enabled
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hz_pre <= '0;
         hz_count <= '0;
         hz_tick <= 1'b0;
      end
      else
      begin
         hz_tick <= 1'b0;
         if (hz60_enable)
         begin
            if (hz_pre == hz_last)
            begin
               hz_pre <= '0;
               hz_count <= hz_count + 32'd1;
               hz_tick <= 1'b1;
            end
            else
               hz_pre <= hz_pre + hz_w'(1);
         end
      end
   end

   assign timers = '{us_count: us_count, hz60_count: hz_count, hz60_tick: hz_tick};

   // the enable is sticky, so a disabled timer never shows a tick
   a_tick_enabled: assert property (@(posedge clk) disable iff (reset)
      !hz60_enable |-> !hz_tick);

endmodule

// File: hw/iob_decode.sv
// i/o board address decode
module iob_decode (
   input  logic              req,
   input  iob_pkg::bus_req_t breq,
   output logic              decode,
   output iob_pkg::iob_op_t  op
);

   logic                       in_window;
   logic [iob_pkg::n_regs-1:0] sel;

   // upper 16 address bits pick the window
   assign in_window = breq.addr[21:6] == iob_pkg::iob_base[21:6];
   assign decode = req & in_window;

   always_comb
   begin
      sel = '0;
      case (breq.addr[5:0])
         iob_pkg::kbd_lo:  sel[iob_pkg::sel_kbd_lo] = 1'b1;
         iob_pkg::kbd_hi:  sel[iob_pkg::sel_kbd_hi] = 1'b1;
         iob_pkg::mouse_y: sel[iob_pkg::sel_mouse_y] = 1'b1;
         iob_pkg::mouse_x: sel[iob_pkg::sel_mouse_x] = 1'b1;
         iob_pkg::beep:    sel[iob_pkg::sel_beep] = 1'b1;
         iob_pkg::kbd_csr: sel[iob_pkg::sel_kbd_csr] = 1'b1;
         iob_pkg::usec_lo: sel[iob_pkg::sel_usec_lo] = 1'b1;
         iob_pkg::usec_hi: sel[iob_pkg::sel_usec_hi] = 1'b1;
         iob_pkg::hz60:    sel[iob_pkg::sel_hz60] = 1'b1;
         // unused offsets still ack but touch nothing
         default:          sel = '0;
      endcase
   end

   assign op = '{
      sel:   sel,
      write: breq.write,
      wdata: breq.wdata,
      valid: decode
   };

   // execute relies on at most one register per access
   always_comb
   begin
      assert final (!op.valid || $onehot0(op.sel));
   end

endmodule

// File: hw/iob_pkg.sv
// i/o board shared definitions
package iob_pkg;

   // 64-word window on the system bus
   localparam logic [21:0] iob_base = 22'o17772000;

   // register offsets inside the window
   localparam logic [5:0] kbd_lo  = 6'o40;
   localparam logic [5:0] kbd_hi  = 6'o41;
   localparam logic [5:0] mouse_y = 6'o42;
   localparam logic [5:0] mouse_x = 6'o43;
   localparam logic [5:0] beep    = 6'o44;
   localparam logic [5:0] kbd_csr = 6'o45;
   localparam logic [5:0] usec_lo = 6'o50;
   localparam logic [5:0] usec_hi = 6'o51;
   localparam logic [5:0] hz60    = 6'o52;

   // bit positions in the one-hot register select
   localparam int sel_kbd_lo  = 0;
   localparam int sel_kbd_hi  = 1;
   localparam int sel_mouse_y = 2;
   localparam int sel_mouse_x = 3;
   localparam int sel_beep    = 4;
   localparam int sel_kbd_csr = 5;
   localparam int sel_usec_lo = 6;
   localparam int sel_usec_hi = 7;
   localparam int sel_hz60    = 8;
   localparam int n_regs      = 9;

   // timer divisors for a 50 MHz clock
   localparam int unsigned us_div_default   = 50;
   localparam int unsigned hz60_div_default = 833333;
   localparam int hz60_div_w = 20;

   // interrupt vectors
   localparam logic [7:0] vec_kbd   = 8'o260;
   localparam logic [7:0] vec_mouse = 8'o264;
   localparam logic [7:0] vec_clk   = 8'o270;

   typedef struct packed {
      logic [21:0] addr;
      logic [31:0] wdata;
      logic        write;
   } bus_req_t;

   typedef struct packed {
      logic [n_regs-1:0] sel;
      logic              write;
      logic [31:0]       wdata;
      logic              valid;
   } iob_op_t;

   typedef struct packed {
      logic        head;
      logic        middle;
      logic        tail;
      logic [11:0] x;
      logic [11:0] y;
      logic [1:0]  rawx;
      logic [1:0]  rawy;
   } mouse_evt_t;

   typedef struct packed {
      logic [31:0] us_count;
      logic [31:0] hz60_count;
      logic        hz60_tick;
   } timer_t;

endpackage
